// File: dv/tcu_fedp_tb.sv
`timescale 1ns/1ps
`include "tcu_consts.svh"

module tcu_fedp_tb;
    import tcu_pkg::*;

    localparam int PHASE_LEN = 40;  // requests per format phase
    localparam int STALL_LEN = 40;
    localparam int BAD_LEN   = 30;
    localparam int N_REQ     = 4 * PHASE_LEN + STALL_LEN + BAD_LEN;
    localparam int LIMIT_NS  = (N_REQ + 50) * 10 * 4;

    // expected result for one accepted request
    typedef struct packed {
        logic [31:0] d_val;
        logic        fmt_err;
        int          stamp;    // enabled edges before the request
        int          id;       // issue number
    } exp_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        enable;
    logic        issue;
    fedp_req_t   req;
    fedp_rsp_t   rsp;
    logic        done;

    logic [15:0] lfsr = 16'd40;
    exp_t        exp_q[$];
    exp_t        head;
    exp_t        new_exp;
    logic        head_have = 1'b0;
    int          en_cnt    = 0;  // enabled edges seen since reset
    int          n_taken   = 0;
    int          n_done    = 0;
    int          err_cnt   = 0;
    bit          count_ok;

    tcu_fedp_top i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .issue  (issue),
        .req    (req),
        .rsp    (rsp),
        .done   (done)
    );

    always #5 clk = ~clk;

    // fibonacci lfsr with taps 16 14 13 11 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] operand();
        if (rand_bits(3) == 32'd0) begin
            return '1;  // all ones now and then
        end
        return rand_bits(32);
    endfunction

    function automatic bit is_legal(input logic [3:0] code);
        return code == `TCU_FMT_INT8 || code == `TCU_FMT_UINT8 ||
               code == `TCU_FMT_INT4 || code == `TCU_FMT_UINT4;
    endfunction

    function automatic logic [3:0] pick_legal();
        case (rand_bits(2))
            32'd0:   return `TCU_FMT_INT8;
            32'd1:   return `TCU_FMT_UINT8;
            32'd2:   return `TCU_FMT_INT4;
            default: return `TCU_FMT_UINT4;
        endcase
    endfunction

    function automatic logic [3:0] pick_illegal();
        logic [3:0] code;
        code = 4'(rand_bits(4));
        while (is_legal(code)) begin
            code = 4'(rand_bits(4));
        end
        return code;
    endfunction

    // one packed element as a plain integer
    function automatic int elem(input logic [31:0] word, input int idx, input int width,
                                input bit sgn);
        int v;
        int half;
        half = 1 << (width - 1);
        v = int'((word >> (idx * width)) & ((32'd1 << width) - 32'd1));
        if (sgn && v >= half) begin
            v = v - 2 * half;
        end
        return v;
    endfunction

    function automatic exp_t model_result(input fedp_req_t r);
        exp_t        e;
        int          width;
        bit          sgn;
        bit          legal;
        logic [31:0] acc;
        legal = 1'b1;
        sgn   = 1'b0;
        width = 8;
        case (r.fmt)
            `TCU_FMT_INT8:  sgn = 1'b1;
            `TCU_FMT_UINT8: width = 8;
            `TCU_FMT_INT4:  begin
                width = 4;
                sgn   = 1'b1;
            end
            `TCU_FMT_UINT4: width = 4;
            default:        legal = 1'b0;
        endcase
        acc = r.c_val;
        if (legal) begin
            for (int l = 0; l < `TCU_LANES; l++) begin
                for (int k = 0; k < 32 / width; k++) begin
                    acc = acc + elem(r.a_row[l], k, width, sgn) *
                                elem(r.b_col[l], k, width, sgn);  // wraps mod 2^32
                end
            end
        end
        e         = '0;
        e.d_val   = acc;
        e.fmt_err = !legal;
        return e;
    endfunction

    // consume on an enabled done and record accepted issues
    always @(posedge clk) begin
        if (rst_n && done && enable) begin
            if (exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            n_done++;
        end
        if (rst_n && issue && enable) begin
            new_exp       = model_result(req);
            new_exp.stamp = en_cnt;
            new_exp.id    = n_taken;
            exp_q.push_back(new_exp);
            n_taken++;
        end
        if (rst_n && enable) begin
            en_cnt++;
        end
    end

    always @(negedge clk) begin
        head_have = exp_q.size() != 0;
        if (exp_q.size() != 0) begin
            head = exp_q[0];
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !done && !rsp.fmt_err)
        else begin
            err_cnt++;
            $display("done or fmt_err went high during reset");
        end

    a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n) done |-> head_have)
        else begin
            err_cnt++;
            $display("done came with no request outstanding");
        end

    a_d_val: assert property (@(posedge clk) disable iff (!rst_n)
        done && head_have |-> rsp.d_val == head.d_val)
        else begin
            err_cnt++;
            $display("[FAIL] rsp.d_val req %0d expected %h got %h",
                     head.id, head.d_val, $sampled(rsp.d_val));
        end

    a_fmt_err: assert property (@(posedge clk) disable iff (!rst_n)
        done && head_have |-> rsp.fmt_err == head.fmt_err)
        else begin
            err_cnt++;
            $display("[FAIL] rsp.fmt_err req %0d expected %h got %h",
                     head.id, head.fmt_err, $sampled(rsp.fmt_err));
        end

    // latency in enabled edges only
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        done && enable && head_have |-> en_cnt == head.stamp + `TCU_TOTAL_LAT)
        else begin
            err_cnt++;
            $display("[FAIL] done latency req %0d expected %h got %h",
                     head.id, 32'(`TCU_TOTAL_LAT), $sampled(en_cnt) - head.stamp);
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !enable |=> $stable(rsp) && $stable(done))
        else begin
            err_cnt++;
            $display("rsp or done moved while enable was low");
        end

    task automatic issue_one(input logic [3:0] code, input bit stall);
        int gap;
        @(negedge clk);
        req.fmt = code;
        for (int i = 0; i < `TCU_LANES; i++) begin
            req.a_row[i] = operand();
            req.b_col[i] = operand();
        end
        req.c_val = rand_bits(32);
        issue     = 1'b1;
        enable    = stall ? (rand_bits(2) != 32'd0) : 1'b1;
        gap       = (rand_bits(1) != 32'd0) ? int'(rand_bits(1)) + 1 : 0;
        repeat (gap) begin
            @(negedge clk);
            issue  = 1'b0;
            enable = stall ? (rand_bits(1) != 32'd0) : 1'b1;
        end
    endtask

    initial begin
        rst_n  = 1'b0;
        enable = 1'b0;
        issue  = 1'b0;
        req    = '0;
        repeat (8) @(negedge clk);
        rst_n  = 1'b1;
        enable = 1'b1;
        repeat (6) @(negedge clk);  // no result may come out while idle

        repeat (PHASE_LEN) issue_one(`TCU_FMT_INT8, 1'b0);
        repeat (PHASE_LEN) issue_one(`TCU_FMT_UINT8, 1'b0);
        repeat (PHASE_LEN) issue_one(`TCU_FMT_INT4, 1'b0);
        repeat (PHASE_LEN) issue_one(`TCU_FMT_UINT4, 1'b0);
        repeat (STALL_LEN) issue_one(pick_legal(), 1'b1);
        repeat (BAD_LEN) issue_one((rand_bits(1) != 32'd0) ? pick_illegal() : pick_legal(), 1'b0);

        @(negedge clk);
        issue  = 1'b0;
        enable = 1'b1;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (6) @(negedge clk);

        count_ok = (n_done == n_taken) && (n_taken > 0);
        if (!count_ok) begin
            $display("result count does not match: %0d taken, %0d returned", n_taken, n_done);
        end
        $display("errors %0d, requests taken %0d, results %0d", err_cnt, n_taken, n_done);
        if (err_cnt == 0 && count_ok) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired, the run hung waiting for results");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+src
src/tcu_pkg.sv
src/tcu_fedp_ctrl.sv
src/tcu_lane_mul.sv
src/tcu_reduce_acc.sv
src/tcu_fedp_top.sv
dv/tcu_fedp_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the fused dot-product testbench with verilator
cd "$(dirname "$0")" || exit 1

sim_out=""

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module tcu_fedp_tb -o tcu_fedp_sim \
    && sim_out="$(./obj_dir/tcu_fedp_sim)"

echo "$sim_out"

echo "$sim_out" | grep -qx "Result: PASSED" \
    && exit 0 \
    || { echo "simulation did not pass"; exit 1; }

// File: src/tcu_consts.svh
`ifndef TCU_CONSTS_SVH
`define TCU_CONSTS_SVH

// 32-bit words per row and per column (2, 4 or 8)
`define TCU_LANES 4

// pipeline depths in enabled cycles
`define TCU_MUL_LAT 2
`define TCU_ACC_LAT 2
`define TCU_TOTAL_LAT (`TCU_MUL_LAT + `TCU_ACC_LAT)

// raw format codes on the request bus, integer group only
`define TCU_FMT_INT8  4'b1001
`define TCU_FMT_UINT8 4'b1010
`define TCU_FMT_INT4  4'b1011
`define TCU_FMT_UINT4 4'b1100

// element widths per packed format
`define TCU_W8_ELEMS 4
`define TCU_W4_ELEMS 8

`endif

// File: src/tcu_fedp_ctrl.sv
`timescale 1ns/1ps
`include "tcu_consts.svh"

module tcu_fedp_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              enable,
    input  logic              issue,
    input  logic [3:0]        fmt_raw,
    output tcu_pkg::tcu_fmt_e op,
    output logic              done,
    output logic              fmt_err
);
    import tcu_pkg::*;

    localparam int DEPTH = `TCU_TOTAL_LAT;

    logic [DEPTH-1:0] vld_sr;  // one bit per pipeline stage
    logic [DEPTH-1:0] bad_sr;
    logic             take;    // request actually enters the pipe

    // lanes see the decoded op in the issue cycle
    always_comb begin
        case (fmt_raw)
            `TCU_FMT_INT8:  op = FMT_INT8;
            `TCU_FMT_UINT8: op = FMT_UINT8;
            `TCU_FMT_INT4:  op = FMT_INT4;
            `TCU_FMT_UINT4: op = FMT_UINT4;
            default:        op = FMT_BAD;
        endcase
    end

    assign take = issue & enable;

    // valid and bad-format bits freeze with the datapath
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
            bad_sr <= '0;
        end else if (enable) begin
            vld_sr <= {vld_sr[DEPTH-2:0], take};
            bad_sr <= {bad_sr[DEPTH-2:0], take & (op == FMT_BAD)};
        end
    end

    assign done    = vld_sr[DEPTH-1];
    assign fmt_err = bad_sr[DEPTH-1];  // lines up with d_val

    // an error flag must always come with its result
    a_err_needs_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        fmt_err |-> done
    ) else $error("fmt_err raised without done");

endmodule

// File: src/tcu_fedp_top.sv
`timescale 1ns/1ps
`include "tcu_consts.svh"

module tcu_fedp_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               enable,
    input  logic               issue,
    input  tcu_pkg::fedp_req_t req,
    output tcu_pkg::fedp_rsp_t rsp,
    output logic               done
);
    import tcu_pkg::*;

    tcu_fmt_e                    op;
    logic [`TCU_LANES-1:0][31:0] lane_sum;
    logic [31:0]                 d_val;
    logic                        fmt_err;

    tcu_fedp_ctrl i_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (enable),
        .issue   (issue),
        .fmt_raw (req.fmt),
        .op      (op),
        .done    (done),
        .fmt_err (fmt_err)
    );

    // one multiplier per word pair
    for (genvar i = 0; i < `TCU_LANES; i++) begin : g_lane
        tcu_lane_mul i_lane (
            .clk      (clk),
            .rst_n    (rst_n),
            .enable   (enable),
            .op       (op),
            .a_word   (req.a_row[i]),
            .b_word   (req.b_col[i]),
            .lane_sum (lane_sum[i])
        );
    end

    tcu_reduce_acc i_reduce (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .lane_sum (lane_sum),
        .c_val    (req.c_val),
        .d_val    (d_val)
    );

    assign rsp.d_val   = d_val;
    assign rsp.fmt_err = fmt_err;  // same cycle as done

endmodule

// File: src/tcu_lane_mul.sv
`timescale 1ns/1ps
`include "tcu_consts.svh"

module tcu_lane_mul (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              enable,
    input  tcu_pkg::tcu_fmt_e op,
    input  logic [31:0]       a_word,
    input  logic [31:0]       b_word,
    output logic [31:0]       lane_sum
);
    import tcu_pkg::*;

    logic [1:0][31:0] part_d;  // half-word partial sums
    logic [1:0][31:0] part_q;
    logic [31:0]      sum_q;

    // products of one 16-bit half, sign or zero extended to 32 bits
    // low 32 bits of the unsigned multiply are the two's complement result
    function automatic logic [31:0] half_sum(
        input tcu_fmt_e    fmt,
        input logic [15:0] a,
        input logic [15:0] b
    );
        logic        sgn;
        logic [31:0] acc;
        logic [31:0] ea;
        logic [31:0] eb;
        sgn = fmt_is_signed(fmt);
        acc = '0;
        case (fmt)
            FMT_INT8, FMT_UINT8: begin
                for (int j = 0; j < `TCU_W8_ELEMS / 2; j++) begin
                    ea  = {{24{sgn & a[8*j+7]}}, a[8*j +: 8]};
                    eb  = {{24{sgn & b[8*j+7]}}, b[8*j +: 8]};
                    acc = acc + ea * eb;
                end
            end
            FMT_INT4, FMT_UINT4: begin
                for (int j = 0; j < `TCU_W4_ELEMS / 2; j++) begin
                    ea  = {{28{sgn & a[4*j+3]}}, a[4*j +: 4]};
                    eb  = {{28{sgn & b[4*j+3]}}, b[4*j +: 4]};
                    acc = acc + ea * eb;
                end
            end
            default: acc = '0;  // bad format contributes nothing
        endcase
        return acc;
    endfunction

    always_comb begin
        part_d[0] = half_sum(op, a_word[15:0], b_word[15:0]);
        part_d[1] = half_sum(op, a_word[31:16], b_word[31:16]);
    end

    // mul stage 1 holds the halves, stage 2 their total
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            part_q <= '0;
            sum_q  <= '0;
        end else if (enable) begin
            part_q <= part_d;
            sum_q  <= part_q[0] + part_q[1];  // wraps
        end
    end

    assign lane_sum = sum_q;

    // decoded op comes from the control block, must be clean when used
    a_op_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        enable |-> !$isunknown(op)
    ) else $error("lane op unknown while enabled");

endmodule

// File: src/tcu_pkg.sv
`include "tcu_consts.svh"

package tcu_pkg;

    // decoded operation, anything unknown ends up as FMT_BAD
    typedef enum logic [2:0] {
        FMT_INT8,
        FMT_UINT8,
        FMT_INT4,
        FMT_UINT4,
        FMT_BAD
    } tcu_fmt_e;

    // one dot-product request
    typedef struct packed {
        logic [3:0]                  fmt;    // raw format code
        logic [`TCU_LANES-1:0][31:0] a_row;  // row words, lane 0 in the low bits
        logic [`TCU_LANES-1:0][31:0] b_col;  // column words
        logic [31:0]                 c_val;  // addend
    } fedp_req_t;

    // result beat, valid with done
    typedef struct packed {
        logic [31:0] d_val;    // wrapped dot product plus addend
        logic        fmt_err;  // request used an unsupported format
    } fedp_rsp_t;

    // signed element types see sign extension
    function automatic logic fmt_is_signed(input tcu_fmt_e fmt);
        return (fmt == FMT_INT8) || (fmt == FMT_INT4);
    endfunction

endpackage

// File: src/tcu_reduce_acc.sv
`timescale 1ns/1ps
`include "tcu_consts.svh"

module tcu_reduce_acc (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        enable,
    input  logic [`TCU_LANES-1:0][31:0] lane_sum,
    input  logic [31:0]                 c_val,
    output logic [31:0]                 d_val
);

    localparam int PAIRS = `TCU_LANES / 2;

    logic [`TCU_MUL_LAT-1:0][31:0] c_pipe;  // addend waits for the lanes
    logic [PAIRS-1:0][31:0]        pair_d;
    logic [PAIRS-1:0][31:0]        pair_q;
    logic [31:0]                   c_q;
    logic [31:0]                   total_d;
    logic [31:0]                   d_q;

    // addend delay, matches the multiply stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_pipe <= '0;
        end else if (enable) begin
            c_pipe[0] <= c_val;
            for (int i = 1; i < `TCU_MUL_LAT; i++) begin
                c_pipe[i] <= c_pipe[i-1];
            end
        end
    end

    // first tree level
    always_comb begin
        for (int p = 0; p < PAIRS; p++) begin
            pair_d[p] = lane_sum[2*p] + lane_sum[2*p+1];
        end
    end

    // remaining levels folded into one sum
    always_comb begin
        total_d = c_q;
        for (int p = 0; p < PAIRS; p++) begin
            total_d = total_d + pair_q[p];
        end
    end

    // acc stage 1 pairs plus addend, stage 2 final result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_q <= '0;
            c_q    <= '0;
            d_q    <= '0;
        end else if (enable) begin
            pair_q <= pair_d;
            c_q    <= c_pipe[`TCU_MUL_LAT-1];
            d_q    <= total_d;  // mod 2^32
        end
    end

    assign d_val = d_q;

endmodule
